// ==== shapi_pkg.sv ====
// --------------------
// shared definitions for the SHAPI register block of the PIO endpoint
// widths, word offsets of the register map, identity words and the
// write-sequencer state type; imported by every RTL file
// --------------------
package shapi_pkg;

    // widths
    localparam int addr_w     = 11;   // register address, in words
    localparam int data_w     = 32;
    localparam int be_w       = 4;    // one enable per byte lane
    localparam int dma_size_w = 21;   // dma byte size field
    localparam int n_dma_buf  = 8;    // dma buffer host-address slots
    localparam int buf_idx_w  = 3;    // current buffer, status bits 2..0

    // --------------------
    // device area
    // --------------------
    localparam int dev_id_n = 10;
    localparam logic [data_w-1:0] dev_id_words [dev_id_n] = '{
        32'h5348_0101,   // magic + major/minor
        32'h0000_0040,   // next header, points at the dma module
        32'h0A51_0042,   // hw id / vendor
        32'h0F17_0042,   // fw id / vendor
        32'h0001_0300,   // fw major/minor/patch
        32'h6A3C_91E0,   // build stamp
        32'h5049_4F5F,   // "PIO_"
        32'h5348_4150,   // "SHAP"
        32'h495F_4550,   // "I_EP"
        32'hC000_0000    // capabilities, full and soft reset
    };
    localparam logic [addr_w-1:0] dev_status_addr  = 11'h00A;  // reads zero
    localparam logic [addr_w-1:0] dev_control_addr = 11'h00B;  // reads zero
    localparam logic [addr_w-1:0] dev_scratch_addr = 11'h00F;
    localparam logic [data_w-1:0] scratch_rst_val  = 32'h0000_00BB;

    // --------------------
    // dma module area
    // --------------------
    localparam logic [addr_w-1:0] mod_base = 11'h040;
    localparam int mod_id_n = 7;
    localparam logic [data_w-1:0] mod_id_words [mod_id_n] = '{
        32'h5348_4D01,   // module magic + version
        32'h0000_0000,   // last module in the chain
        32'h00DA_0042,   // fw id / vendor
        32'h0001_0200,   // fw version
        32'h444D_415F,   // name, low word "DMA_"
        32'h4348_3031,   // name, high word "CH01"
        32'hC000_0001    // capabilities, multi interrupt
    };

    // offsets from mod_base
    localparam logic [addr_w-1:0] mod_status_off     = 11'h007;
    localparam logic [addr_w-1:0] mod_control_off    = 11'h008;
    localparam logic [addr_w-1:0] mod_irq_id_off     = 11'h009;
    localparam logic [addr_w-1:0] mod_irq_clear_off  = 11'h00A;
    localparam logic [addr_w-1:0] mod_irq_mask_off   = 11'h00B;
    localparam logic [addr_w-1:0] mod_irq_flag_off   = 11'h00C;
    localparam logic [addr_w-1:0] mod_irq_active_off = 11'h00D;
    localparam logic [addr_w-1:0] dma_status_off     = 11'h010;
    localparam logic [addr_w-1:0] dma_control_off    = 11'h011;
    localparam logic [addr_w-1:0] dma_size_off       = 11'h012;
    localparam logic [addr_w-1:0] dma_max_bytes_off  = 11'h013;
    localparam logic [addr_w-1:0] tlp_payload_off    = 11'h014;
    localparam logic [addr_w-1:0] dma_addr_base_off  = 11'h020;  // slot 0, slots follow
    localparam logic [addr_w-1:0] dma_ch1_off        = 11'h028;

    // constant module words
    localparam logic [data_w-1:0] mod_irq_id    = 32'h0000_0010;
    localparam logic [data_w-1:0] dma_max_bytes = 32'h0010_0000;  // 1 MiB
    localparam logic [data_w-1:0] tlp_payload   = 32'h0000_0080;  // 128 byte tlp

    // write sequence
    typedef enum logic [1:0] {
        wr_idle,
        wr_wait,
        wr_read,
        wr_write
    } wr_state_t;

endpackage

// ==== pio_wr_seq.sv ====
// --------------------
// write sequencer of the register block
// takes a one-cycle write strobe from the rx engine, walks
// idle/wait/read/write and hands the reordered, lane-masked word to the
// registers as a one-cycle commit; busy covers the whole sequence
// --------------------
module pio_wr_seq
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en_i,
    input  logic [shapi_pkg::addr_w-1:0]  wr_addr_i,
    input  logic [shapi_pkg::be_w-1:0]    wr_be_i,
    input  logic [shapi_pkg::data_w-1:0]  wr_data_i,
    output logic                          wr_busy_o,
    output logic                          commit_o,
    output logic [shapi_pkg::addr_w-1:0]  commit_addr_o,
    output logic [shapi_pkg::data_w-1:0]  commit_data_o
);
    import shapi_pkg::*;

    wr_state_t            state;
    logic                 accept;      // strobe seen while idle
    logic [addr_w-1:0]    addr_q;
    logic [be_w-1:0]      be_q;
    logic [data_w-1:0]    data_q;
    logic [data_w-1:0]    swap_data;   // reordered, disabled lanes zero

    assign accept    = wr_en_i && (state == wr_idle);
    assign wr_busy_o = wr_en_i | (state != wr_idle);

    // tlp payload has the lowest address byte in bits 31..24
    // stored lane n takes host byte 3-n, gated by its own enable
    always_comb
    begin
        for (int n = 0; n < be_w; n++)
        begin
            swap_data[8*n +: 8] = be_q[n] ? data_q[8*(be_w-1-n) +: 8] : 8'h00;
        end
    end

    // --------------------
    // sequence fsm
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= wr_idle;
            commit_o <= 1'b0;
        end
        else
        begin
            commit_o <= 1'b0;                 // single pulse only
            case (state)
                wr_idle:
                begin
                    if (wr_en_i)
                        state <= wr_wait;
                end
                wr_wait:  state <= wr_read;   // timing step
                wr_read:  state <= wr_write;  // timing step, no real rmw
                wr_write:
                begin
                    commit_o <= 1'b1;
                    state    <= wr_idle;      // next write may start here
                end
                default:  state <= wr_idle;
            endcase
        end
    end

    // payload, captured at acceptance and at the write step
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= wr_addr_i;
            be_q   <= wr_be_i;
            data_q <= wr_data_i;
        end
        if (state == wr_write)
        begin
            commit_addr_o <= addr_q;          // held apart from addr_q, which
            commit_data_o <= swap_data;       // a back-to-back write reloads
        end
    end

endmodule

// ==== dma_addr_slot.sv ====
// --------------------
// one dma buffer host-address slot
// loads on a commit to its own word, flags reads of that word and
// flags when the dma engine points at this buffer
// --------------------
module dma_addr_slot #(
    parameter int slot_idx = 0   // below n_dma_buf
)
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             commit_i,
    input  logic [shapi_pkg::addr_w-1:0]     commit_addr_i,
    input  logic [shapi_pkg::data_w-1:0]     commit_data_i,
    input  logic [shapi_pkg::addr_w-1:0]     rd_addr_i,
    input  logic [shapi_pkg::buf_idx_w-1:0]  buf_idx_i,
    output logic [shapi_pkg::data_w-1:0]     addr_o,
    output logic                             rd_hit_o,
    output logic                             buf_hit_o
);
    import shapi_pkg::*;

    localparam logic [addr_w-1:0] own_addr =
        addr_w'(mod_base + dma_addr_base_off + slot_idx);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            addr_o <= '0;
        else if (commit_i && (commit_addr_i == own_addr))
            addr_o <= commit_data_i;          // full word, no field limits
    end

    assign rd_hit_o  = (rd_addr_i == own_addr);
    assign buf_hit_o = (buf_idx_i == buf_idx_w'(slot_idx));  // current buffer

endmodule

// ==== shapi_ctrl_regs.sv ====
// --------------------
// writable registers of the device and dma module areas
// scratch, module control, irq clear/mask, dma control, dma byte size
// and the channel-1 host address, all loaded from the commit word
// --------------------
module shapi_ctrl_regs
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              commit_i,
    input  logic [shapi_pkg::addr_w-1:0]      commit_addr_i,
    input  logic [shapi_pkg::data_w-1:0]      commit_data_i,
    output logic [shapi_pkg::data_w-1:0]      scratch_o,
    output logic [1:0]                        mod_control_o,   // full rst, soft rst
    output logic [shapi_pkg::data_w-1:0]      irq_clear_o,
    output logic [shapi_pkg::data_w-1:0]      irq_mask_o,
    output logic [shapi_pkg::data_w-1:0]      control_o,
    output logic [shapi_pkg::dma_size_w-1:0]  dma_size_o,
    output logic [shapi_pkg::data_w-1:0]      dma_ha_ch1_o
);
    import shapi_pkg::*;

    // --------------------
    // commit decode
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scratch_o     <= scratch_rst_val;    // only non-zero reset
            mod_control_o <= 2'b00;
            irq_clear_o   <= '0;
            irq_mask_o    <= '0;
            control_o     <= '0;
            dma_size_o    <= '0;
            dma_ha_ch1_o  <= '0;
        end
        else if (commit_i)
        begin
            case (commit_addr_i)
                dev_scratch_addr:
                    scratch_o <= commit_data_i;
                mod_base + mod_control_off:
                    mod_control_o <= commit_data_i[data_w-1 -: 2];  // bits 31..30
                mod_base + mod_irq_clear_off:
                    irq_clear_o <= commit_data_i;
                mod_base + mod_irq_mask_off:
                    irq_mask_o <= commit_data_i;
                mod_base + dma_control_off:
                    control_o <= commit_data_i;
                mod_base + dma_size_off:
                    dma_size_o <= commit_data_i[dma_size_w-1:0];    // byte count
                mod_base + dma_ch1_off:
                    dma_ha_ch1_o <= commit_data_i;
                default: ;   // slots decode their own word, rest is read only
            endcase
        end
    end

endmodule

// ==== shapi_rd_mux.sv ====
// --------------------
// read side of the register block, purely combinational
// picks the raw word for rd_addr_i, then swaps and masks the lanes
// also forms the channel-0 host address from the slot buffer hits
// --------------------
module shapi_rd_mux
(
    input  logic [shapi_pkg::addr_w-1:0]      rd_addr_i,
    input  logic [shapi_pkg::be_w-1:0]        rd_be_i,
    input  logic [shapi_pkg::data_w-1:0]      status_i,
    input  logic [shapi_pkg::data_w-1:0]      scratch_i,
    input  logic [1:0]                        mod_control_i,
    input  logic [shapi_pkg::data_w-1:0]      irq_clear_i,
    input  logic [shapi_pkg::data_w-1:0]      irq_mask_i,
    input  logic [shapi_pkg::data_w-1:0]      control_i,
    input  logic [shapi_pkg::dma_size_w-1:0]  dma_size_i,
    input  logic [shapi_pkg::data_w-1:0]      dma_ha_ch1_i,
    input  logic [shapi_pkg::data_w-1:0]      slot_addr_i [shapi_pkg::n_dma_buf],
    input  logic [shapi_pkg::n_dma_buf-1:0]   rd_hit_i,
    input  logic [shapi_pkg::n_dma_buf-1:0]   buf_hit_i,
    output logic [shapi_pkg::data_w-1:0]      rd_data_o,
    output logic [shapi_pkg::data_w-1:0]      dma_ha_ch0_o
);
    import shapi_pkg::*;

    logic [data_w-1:0] raw;   // word before lane handling

    // --------------------
    // raw word select
    // --------------------
    always_comb
    begin
        raw = data_w'(rd_addr_i);   // unmapped reads echo the address

        for (int i = 0; i < dev_id_n; i++)
        begin
            if (rd_addr_i == addr_w'(i))
                raw = dev_id_words[i];
        end
        for (int i = 0; i < mod_id_n; i++)
        begin
            if (rd_addr_i == addr_w'(mod_base + i))
                raw = mod_id_words[i];
        end

        case (rd_addr_i)
            dev_status_addr,
            dev_control_addr:               raw = '0;   // no endian/reset bits
            dev_scratch_addr:               raw = scratch_i;
            mod_base + mod_status_off:      raw = '0;
            mod_base + mod_control_off:     raw = {mod_control_i, {(data_w-2){1'b0}}};
            mod_base + mod_irq_id_off:      raw = mod_irq_id;
            mod_base + mod_irq_clear_off:   raw = irq_clear_i;
            mod_base + mod_irq_mask_off:    raw = irq_mask_i;
            mod_base + mod_irq_flag_off,
            mod_base + mod_irq_active_off:  raw = '0;   // no live irq sources
            mod_base + dma_status_off:      raw = status_i;
            mod_base + dma_control_off:     raw = control_i;
            mod_base + dma_size_off:        raw = data_w'(dma_size_i);
            mod_base + dma_max_bytes_off:   raw = dma_max_bytes;
            mod_base + tlp_payload_off:     raw = tlp_payload;
            mod_base + dma_ch1_off:         raw = dma_ha_ch1_i;
            default: ;
        endcase

        // at most one slot claims an address
        for (int i = 0; i < n_dma_buf; i++)
        begin
            if (rd_hit_i[i])
                raw = slot_addr_i[i];
        end
    end

    // lane swap back to payload order, enable n gates raw byte n
    always_comb
    begin
        for (int n = 0; n < be_w; n++)
        begin
            rd_data_o[8*(be_w-1-n) +: 8] = rd_be_i[n] ? raw[8*n +: 8] : 8'h00;
        end
    end

    // --------------------
    // channel-0 host address
    // --------------------
    always_comb
    begin
        dma_ha_ch0_o = '0;
        for (int i = 0; i < n_dma_buf; i++)
        begin
            if (buf_hit_i[i])
                dma_ha_ch0_o = dma_ha_ch0_o | slot_addr_i[i];   // one-hot or
        end
    end

endmodule

// ==== pio_ep_shapi_regs.sv ====
// --------------------
// register block of the PCIe PIO endpoint, top level
// write sequencer, control registers, eight dma address slots and the
// combinational read mux; host side is a plain strobe/busy interface
// --------------------
module pio_ep_shapi_regs
(
    input  logic                              clk,
    input  logic                              rst_n,
    // write side
    input  logic [shapi_pkg::addr_w-1:0]      wr_addr_i,
    input  logic [shapi_pkg::be_w-1:0]        wr_be_i,
    input  logic [shapi_pkg::data_w-1:0]      wr_data_i,
    input  logic                              wr_en_i,
    output logic                              wr_busy_o,
    // read side
    input  logic [shapi_pkg::addr_w-1:0]      rd_addr_i,
    input  logic [shapi_pkg::be_w-1:0]        rd_be_i,
    output logic [shapi_pkg::data_w-1:0]      rd_data_o,
    // dma side
    input  logic [shapi_pkg::data_w-1:0]      status_i,
    output logic [shapi_pkg::data_w-1:0]      control_o,
    output logic [shapi_pkg::dma_size_w-1:0]  dma_size_o,
    output logic [shapi_pkg::data_w-1:0]      dma_ha_ch0_o,
    output logic [shapi_pkg::data_w-1:0]      dma_ha_ch1_o
);
    import shapi_pkg::*;

    logic                  commit;
    logic [addr_w-1:0]     commit_addr;
    logic [data_w-1:0]     commit_data;
    logic [data_w-1:0]     scratch;
    logic [1:0]            mod_control;
    logic [data_w-1:0]     irq_clear;
    logic [data_w-1:0]     irq_mask;
    logic [data_w-1:0]     slot_addr [n_dma_buf];
    logic [n_dma_buf-1:0]  rd_hit;
    logic [n_dma_buf-1:0]  buf_hit;
    logic [buf_idx_w-1:0]  buf_idx;

    assign buf_idx = status_i[buf_idx_w-1:0];   // engine's current buffer

    pio_wr_seq u_wr_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en_i       (wr_en_i),
        .wr_addr_i     (wr_addr_i),
        .wr_be_i       (wr_be_i),
        .wr_data_i     (wr_data_i),
        .wr_busy_o     (wr_busy_o),
        .commit_o      (commit),
        .commit_addr_o (commit_addr),
        .commit_data_o (commit_data)
    );

    shapi_ctrl_regs u_ctrl_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_i      (commit),
        .commit_addr_i (commit_addr),
        .commit_data_i (commit_data),
        .scratch_o     (scratch),
        .mod_control_o (mod_control),
        .irq_clear_o   (irq_clear),
        .irq_mask_o    (irq_mask),
        .control_o     (control_o),
        .dma_size_o    (dma_size_o),
        .dma_ha_ch1_o  (dma_ha_ch1_o)
    );

    for (genvar g = 0; g < n_dma_buf; g++)
    begin : g_slot
        dma_addr_slot #(.slot_idx(g)) u_slot (
            .clk           (clk),
            .rst_n         (rst_n),
            .commit_i      (commit),
            .commit_addr_i (commit_addr),
            .commit_data_i (commit_data),
            .rd_addr_i     (rd_addr_i),
            .buf_idx_i     (buf_idx),
            .addr_o        (slot_addr[g]),
            .rd_hit_o      (rd_hit[g]),
            .buf_hit_o     (buf_hit[g])
        );
    end

    shapi_rd_mux u_rd_mux (
        .rd_addr_i     (rd_addr_i),
        .rd_be_i       (rd_be_i),
        .status_i      (status_i),
        .scratch_i     (scratch),
        .mod_control_i (mod_control),
        .irq_clear_i   (irq_clear),
        .irq_mask_i    (irq_mask),
        .control_i     (control_o),
        .dma_size_i    (dma_size_o),
        .dma_ha_ch1_i  (dma_ha_ch1_o),
        .slot_addr_i   (slot_addr),
        .rd_hit_i      (rd_hit),
        .buf_hit_i     (buf_hit),
        .rd_data_o     (rd_data_o),
        .dma_ha_ch0_o  (dma_ha_ch0_o)
    );

endmodule

// ==== tb_pio_ep_shapi_regs.sv ====
// --------------------
// testbench for the SHAPI register block of the PIO endpoint
// applies a table of register writes and reads, then loads the dma
// buffer slots with random words and walks the buffer index in status_i
// --------------------
module tb_pio_ep_shapi_regs;
    timeunit 1ns;
    timeprecision 1ps;
    import shapi_pkg::*;

    localparam bit op_rd     = 1'b0;
    localparam bit op_wr     = 1'b1;
    localparam int rst_cycles = 10;
    localparam int extra_ops  = 34;   // slot and status steps after the table

    logic                   clk;
    logic                   rst_n;
    logic [addr_w-1:0]      wr_addr_i;
    logic [be_w-1:0]        wr_be_i;
    logic [data_w-1:0]      wr_data_i;
    logic                   wr_en_i;
    logic                   wr_busy_o;
    logic [addr_w-1:0]      rd_addr_i;
    logic [be_w-1:0]        rd_be_i;
    logic [data_w-1:0]      rd_data_o;
    logic [data_w-1:0]      status_i;
    logic [data_w-1:0]      control_o;
    logic [dma_size_w-1:0]  dma_size_o;
    logic [data_w-1:0]      dma_ha_ch0_o;
    logic [data_w-1:0]      dma_ha_ch1_o;

    // stimulus table, one entry per row
    string                  row_name [$];
    bit                     row_op   [$];
    logic [addr_w-1:0]      row_addr [$];
    logic [be_w-1:0]        row_be   [$];
    logic [data_w-1:0]      row_data [$];
    logic [data_w-1:0]      row_exp  [$];

    logic [data_w-1:0]      rd_val;
    logic [data_w-1:0]      slot_word [n_dma_buf];
    logic [data_w-1:0]      ch1_word;
    logic [data_w-1:0]      status_val;
    int                     seed_val;
    int unsigned            rnd;
    bit                     table_ready;

    pio_ep_shapi_regs DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_addr_i    (wr_addr_i),
        .wr_be_i      (wr_be_i),
        .wr_data_i    (wr_data_i),
        .wr_en_i      (wr_en_i),
        .wr_busy_o    (wr_busy_o),
        .rd_addr_i    (rd_addr_i),
        .rd_be_i      (rd_be_i),
        .rd_data_o    (rd_data_o),
        .status_i     (status_i),
        .control_o    (control_o),
        .dma_size_o   (dma_size_o),
        .dma_ha_ch0_o (dma_ha_ch0_o),
        .dma_ha_ch1_o (dma_ha_ch1_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // byte order rule: stored byte n is host byte 3-n
    function automatic logic [data_w-1:0] reorder_bytes(input logic [data_w-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic check_equal(input string name, input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
        if (actual !== expected)
        begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_row(input string name, input bit op, input logic [addr_w-1:0] addr,
                           input logic [be_w-1:0] be, input logic [data_w-1:0] data,
                           input logic [data_w-1:0] exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_be.push_back(be);
        row_data.push_back(data);
        row_exp.push_back(exp);
    endtask

    // one-cycle strobe, then wait for busy to fall
    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [be_w-1:0] be,
                             input logic [data_w-1:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        wr_addr_i <= addr;
        wr_be_i   <= be;
        wr_data_i <= data;
        wr_en_i   <= 1'b1;
        @(posedge clk);
        wr_en_i   <= 1'b0;
        @(negedge clk);
        while (wr_busy_o)
        begin
            if (waited == 20)
            begin
                $display("write to %h never finished, wr_busy_o stayed high", addr);
                $display("SOME TESTS FAILED");
                $fatal(1);
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic read_reg(input logic [addr_w-1:0] addr, input logic [be_w-1:0] be,
                            output logic [data_w-1:0] val);
        @(posedge clk);
        rd_addr_i <= addr;
        rd_be_i   <= be;
        @(posedge clk);
        @(negedge clk);        // mid-cycle sample
        val = rd_data_o;
    endtask

    // --------------------
    // stimulus table
    // --------------------
    task automatic build_table();
        // reset values and identity words
        for (int i = 0; i < dev_id_n; i++)
            add_row($sformatf("dev_id_%0d", i), op_rd, addr_w'(i), 4'hF, '0,
                    reorder_bytes(dev_id_words[i]));
        add_row("dev_status", op_rd, dev_status_addr, 4'hF, '0, '0);
        add_row("dev_control", op_rd, dev_control_addr, 4'hF, '0, '0);
        add_row("scratch_rst", op_rd, dev_scratch_addr, 4'hF, '0, 32'hBB00_0000);
        for (int i = 0; i < mod_id_n; i++)
            add_row($sformatf("mod_id_%0d", i), op_rd, addr_w'(mod_base + i), 4'hF, '0,
                    reorder_bytes(mod_id_words[i]));
        add_row("mod_status", op_rd, mod_base + mod_status_off, 4'hF, '0, '0);
        add_row("mod_ctrl_rst", op_rd, mod_base + mod_control_off, 4'hF, '0, '0);
        add_row("irq_id", op_rd, mod_base + mod_irq_id_off, 4'hF, '0, reorder_bytes(mod_irq_id));
        add_row("irq_clr_rst", op_rd, mod_base + mod_irq_clear_off, 4'hF, '0, '0);
        add_row("irq_mask_rst", op_rd, mod_base + mod_irq_mask_off, 4'hF, '0, '0);
        add_row("irq_flag", op_rd, mod_base + mod_irq_flag_off, 4'hF, '0, '0);
        add_row("irq_active", op_rd, mod_base + mod_irq_active_off, 4'hF, '0, '0);
        add_row("dma_status_rst", op_rd, mod_base + dma_status_off, 4'hF, '0, '0);
        add_row("dma_ctrl_rst", op_rd, mod_base + dma_control_off, 4'hF, '0, '0);
        add_row("dma_size_rst", op_rd, mod_base + dma_size_off, 4'hF, '0, '0);
        add_row("max_bytes", op_rd, mod_base + dma_max_bytes_off, 4'hF, '0,
                reorder_bytes(dma_max_bytes));
        add_row("tlp_payload", op_rd, mod_base + tlp_payload_off, 4'hF, '0,
                reorder_bytes(tlp_payload));
        for (int i = 0; i < n_dma_buf; i++)
            add_row($sformatf("slot_rst_%0d", i), op_rd,
                    addr_w'(mod_base + dma_addr_base_off + i), 4'hF, '0, '0);
        add_row("ch1_rst", op_rd, mod_base + dma_ch1_off, 4'hF, '0, '0);

        // full-width write then read, narrow fields cut
        add_row("scratch_wr", op_wr, dev_scratch_addr, 4'hF, 32'hDEAD_BEEF, '0);
        add_row("scratch_rd", op_rd, dev_scratch_addr, 4'hF, '0, 32'hDEAD_BEEF);
        add_row("mod_ctrl_wr", op_wr, mod_base + mod_control_off, 4'hF, 32'h1234_56FF, '0);
        add_row("mod_ctrl_rd", op_rd, mod_base + mod_control_off, 4'hF, '0, 32'h0000_00C0);
        add_row("irq_clr_wr", op_wr, mod_base + mod_irq_clear_off, 4'hF, 32'h0000_0001, '0);
        add_row("irq_clr_rd", op_rd, mod_base + mod_irq_clear_off, 4'hF, '0, 32'h0000_0001);
        add_row("irq_mask_wr", op_wr, mod_base + mod_irq_mask_off, 4'hF, 32'hFFFF_0000, '0);
        add_row("irq_mask_rd", op_rd, mod_base + mod_irq_mask_off, 4'hF, '0, 32'hFFFF_0000);
        add_row("dma_ctrl_wr", op_wr, mod_base + dma_control_off, 4'hF, 32'hA5A5_0F0F, '0);
        add_row("dma_ctrl_rd", op_rd, mod_base + dma_control_off, 4'hF, '0, 32'hA5A5_0F0F);
        add_row("dma_size_wr", op_wr, mod_base + dma_size_off, 4'hF, 32'h7856_3412, '0);
        add_row("dma_size_rd", op_rd, mod_base + dma_size_off, 4'hF, '0, 32'h7856_1400);

        // partial enables, disabled lanes land as zero
        add_row("scratch_be_wr", op_wr, dev_scratch_addr, 4'b0101, 32'h1122_3344, '0);
        add_row("scratch_be_rd", op_rd, dev_scratch_addr, 4'hF, '0, 32'h1100_3300);
        add_row("scratch_rd_0011", op_rd, dev_scratch_addr, 4'b0011, '0, 32'h1100_0000);
        add_row("scratch_rd_0100", op_rd, dev_scratch_addr, 4'b0100, '0, 32'h0000_3300);
        add_row("dma_ctrl_rd_1100", op_rd, mod_base + dma_control_off, 4'b1100, '0,
                32'h0000_0F0F);
        add_row("irq_mask_be_wr", op_wr, mod_base + mod_irq_mask_off, 4'b1000,
                32'h0000_00AA, '0);
        add_row("irq_mask_be_rd", op_rd, mod_base + mod_irq_mask_off, 4'hF, '0, 32'h0000_00AA);
        add_row("irq_clr_be_wr", op_wr, mod_base + mod_irq_clear_off, 4'b0001,
                32'hAABB_CCDD, '0);
        add_row("irq_clr_be_rd", op_rd, mod_base + mod_irq_clear_off, 4'hF, '0, 32'hAA00_0000);

        // unmapped, address comes back through the lane swap
        add_row("unmapped_030", op_rd, 11'h030, 4'hF, '0, 32'h3000_0000);
        add_row("unmapped_04e", op_rd, 11'h04E, 4'hF, '0, 32'h4E00_0000);
        add_row("unmapped_7ff", op_rd, 11'h7FF, 4'hF, '0, 32'hFF07_0000);
        add_row("unmapped_7ff_be", op_rd, 11'h7FF, 4'b0010, '0, 32'h0007_0000);
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial
    begin
        wait (table_ready);
        repeat ((row_name.size() + extra_ops) * 10 + rst_cycles) @(posedge clk);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial
    begin
        rst_n      = 1'b0;
        wr_addr_i  = '0;
        wr_be_i    = '0;
        wr_data_i  = '0;
        wr_en_i    = 1'b0;
        rd_addr_i  = '0;
        rd_be_i    = '0;
        status_i   = '0;
        seed_val   = 32'h98dd_038c;
        rnd        = $urandom(seed_val);   // seed once
        build_table();
        table_ready = 1'b1;

        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("busy_rst", '0, 32'(wr_busy_o));
        check_equal("control_rst", '0, control_o);
        check_equal("size_rst", '0, 32'(dma_size_o));
        check_equal("ha_ch0_rst", '0, dma_ha_ch0_o);
        check_equal("ha_ch1_rst", '0, dma_ha_ch1_o);

        for (int r = 0; r < row_name.size(); r++)
        begin
            if (row_op[r] == op_wr)
                write_reg(row_addr[r], row_be[r], row_data[r]);
            else
            begin
                read_reg(row_addr[r], row_be[r], rd_val);
                check_equal(row_name[r], row_exp[r], rd_val);
            end
        end
        check_equal("control_o", 32'h0F0F_A5A5, control_o);   // stored order
        check_equal("dma_size_o", 32'h0014_5678, 32'(dma_size_o));
        check_equal("busy_idle", '0, 32'(wr_busy_o));

        // --------------------
        // buffer host addresses
        // --------------------
        for (int i = 0; i < n_dma_buf; i++)
        begin
            slot_word[i] = $urandom();
            write_reg(addr_w'(mod_base + dma_addr_base_off + i), 4'hF, slot_word[i]);
            read_reg(addr_w'(mod_base + dma_addr_base_off + i), 4'hF, rd_val);
            check_equal($sformatf("slot_rd_%0d", i), slot_word[i], rd_val);
        end
        ch1_word = $urandom();
        write_reg(mod_base + dma_ch1_off, 4'hF, ch1_word);
        read_reg(mod_base + dma_ch1_off, 4'hF, rd_val);
        check_equal("ch1_rd", ch1_word, rd_val);

        for (int s = 0; s < n_dma_buf; s++)
        begin
            status_val = ($urandom() & 32'hFFFF_FFF8) | s;   // index in bits 2..0
            @(posedge clk);
            status_i <= status_val;
            read_reg(mod_base + dma_status_off, 4'hF, rd_val);
            check_equal($sformatf("status_rd_%0d", s), reorder_bytes(status_val), rd_val);
            check_equal($sformatf("ha_ch0_%0d", s), reorder_bytes(slot_word[s]), dma_ha_ch0_o);
            check_equal($sformatf("ha_ch1_%0d", s), reorder_bytes(ch1_word), dma_ha_ch1_o);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
shapi_pkg.sv
pio_wr_seq.sv
dma_addr_slot.sv
shapi_ctrl_regs.sv
shapi_rd_mux.sv
pio_ep_shapi_regs.sv
tb_pio_ep_shapi_regs.sv
